//--- build.f
+incdir+source
source/bf16_pkg.sv
source/math_bf16_comparator.sv
source/bf16_absmax_tree.sv
source/bf16_block_absmax.sv
source/bf16_scale_gen.sv
source/bf16_absmax_quant_top.sv
tb/bf16_absmax_checker.sv
tb/tb_bf16_absmax_quant.sv

//--- Makefile
# Verilator build and run for the BF16 block abs-max unit

VERILATOR ?= verilator
TOP       ?= tb_bf16_absmax_quant
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_bf16_absmax_quant.sv
// Testbench top for the BF16 block abs-max unit
// Clock, reset, seeded random block stimulus and watchdog
// Closing error report and final status

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module tb_bf16_absmax_quant;

    localparam int NUM_BLOCKS  = 300;
    localparam int MAX_BEATS   = 6;
    // Worst case is one beat plus two idle cycles, 8 ns each
    localparam int WATCHDOG_NS = NUM_BLOCKS * MAX_BEATS * 3 * 8 + 1000;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           valid;
    logic                           last;
    logic [`BF16_LANES*`BF16_W-1:0] data;
    logic                           done;
    logic [`BF16_W-1:0]             block_max;
    bf16_pkg::bf16_class_e          max_class;
    logic [7:0]                     shared_exp;
    logic [`BF16_W-1:0]             scale;
    int                             value_errors;
    int                             other_errors;
    int                             pending;
    int                             missing;
    // Last lane value, source of duplicated magnitudes
    logic [`BF16_W-1:0]             prev_value;

    always #4 clk = ~clk;

    bf16_absmax_quant_top u_bf16_absmax_quant_top (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_valid      (valid),
        .i_last       (last),
        .i_data       (data),
        .o_done       (done),
        .o_block_max  (block_max),
        .o_max_class  (max_class),
        .o_shared_exp (shared_exp),
        .o_scale      (scale)
    );

    bf16_absmax_checker u_checker (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_valid        (valid),
        .i_last         (last),
        .i_data         (data),
        .i_done         (done),
        .i_block_max    (block_max),
        .i_max_class    (max_class),
        .i_shared_exp   (shared_exp),
        .i_scale        (scale),
        .o_value_errors (value_errors),
        .o_other_errors (other_errors),
        .o_pending      (pending)
    );

    // ------------------------------
    // Stimulus
    // ------------------------------
    // Mix of plain words, signed zeros, subnormals, small exponents,
    // infinities, NaNs and sign-flipped copies of the previous lane
    function automatic logic [`BF16_W-1:0] rand_value(input logic [`BF16_W-1:0] prev);
        int unsigned pick;
        logic        sign;
        logic [6:0]  mant;
        pick = $urandom % 64;
        sign = 1'($urandom);
        mant = 7'($urandom);
        if (pick < 28) return 16'($urandom);
        if (pick < 36) return {sign, 15'h0000};
        if (pick < 42) return {sign, 8'h00, mant | 7'h01};
        if (pick < 48) return {sign, 8'($urandom % 8), mant};
        if (pick < 50) return {sign, 8'hFF, 7'h00};
        if (pick < 51) return {sign, 8'hFF, mant | 7'h01};
        return {~prev[15], prev[14:0]};
    endfunction

    task automatic drive_beat(input logic is_last, input logic zero_mode);
        int                 lane;
        logic [`BF16_W-1:0] value;
        @(negedge clk);
        for (lane = 0; lane < `BF16_LANES; lane++) begin
            value = zero_mode ? {1'($urandom), 15'h0000} : rand_value(prev_value);
            data[lane*`BF16_W +: `BF16_W] = value;
            prev_value = value;
        end
        valid = 1'b1;
        last  = is_last;
    endtask

    // Idle cycle, last and data toggle but must be ignored
    task automatic drive_idle();
        @(negedge clk);
        valid = 1'b0;
        last  = 1'($urandom);
        data  = {$urandom, $urandom};
    endtask

    initial begin
        int   blk;
        int   beat;
        int   beats;
        int   drain;
        logic zero_mode;
        rst        = 1'b1;
        valid      = 1'b0;
        last       = 1'b0;
        data       = '0;
        prev_value = '0;
        missing    = 0;
        void'($urandom(32'hdec8_e388));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (blk = 0; blk < NUM_BLOCKS; blk++) begin
            beats     = 1 + int'($urandom % MAX_BEATS);
            zero_mode = ($urandom % 12) == 0;
            for (beat = 0; beat < beats; beat++) begin
                drive_beat(beat == beats - 1, zero_mode);
                repeat ($urandom % 3) drive_idle();
            end
        end
        @(negedge clk);
        valid = 1'b0;
        last  = 1'b0;
        // Let the pipeline drain, bounded
        drain = 0;
        while (pending != 0 && drain < 16) begin
            @(negedge clk);
            drain = drain + 1;
        end
        missing = pending;
        if (missing != 0) begin
            $display("%0d block result(s) never arrived on o_done", missing);
        end
        $display("Errors: %0d value, %0d protocol, %0d missing",
                 value_errors, other_errors, missing);
        if (value_errors == 0 && other_errors == 0 && missing == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_bf16_absmax_quant

`default_nettype wire

//--- tb/bf16_absmax_checker.sv
// Reference model and result checker for the BF16 abs-max unit
// Folds accepted beats with its own comparator model
// Queues expected block results and compares them on o_done

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module bf16_absmax_checker (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic                           i_last,
    input  logic [`BF16_LANES*`BF16_W-1:0] i_data,
    input  logic                           i_done,
    input  logic [`BF16_W-1:0]             i_block_max,
    input  bf16_pkg::bf16_class_e          i_max_class,
    input  logic [7:0]                     i_shared_exp,
    input  logic [`BF16_W-1:0]             i_scale,
    output int                             o_value_errors,
    output int                             o_other_errors,
    output int                             o_pending
);

    // ------------------------------
    // Model state
    // ------------------------------
    longint             cycle        = 0;
    logic               in_block     = 1'b0;
    logic [`BF16_W-1:0] run_max      = '0;
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 pending      = 0;
    int                 blocks_done  = 0;
    // Expected block maxima and the cycle their o_done is due
    logic [`BF16_W-1:0] max_q[$];
    longint             due_q[$];

    assign o_value_errors = value_errors;
    assign o_other_errors = other_errors;
    assign o_pending      = pending;

    function automatic logic is_nan(input logic [`BF16_W-1:0] v);
        return (v[14:7] == 8'hFF) && (v[6:0] != 7'h00);
    endfunction

    // NaN first, a keeps a double NaN, then magnitude, a keeps ties
    function automatic logic [`BF16_W-1:0] larger_mag(input logic [`BF16_W-1:0] a,
                                                      input logic [`BF16_W-1:0] b);
        if (is_nan(a)) return a;
        if (is_nan(b)) return b;
        if (b[14:0] > a[14:0]) return b;
        return a;
    endfunction

    function automatic bf16_pkg::bf16_class_e class_of(input logic [`BF16_W-1:0] v);
        if (v[14:7] == 8'h00) return bf16_pkg::BF16_ZERO;
        if (v[14:7] != 8'hFF) return bf16_pkg::BF16_NORMAL;
        if (v[6:0] == 7'h00) return bf16_pkg::BF16_INF;
        return bf16_pkg::BF16_NAN;
    endfunction

    // Power of two with exponent minus headroom, flushed below 1
    function automatic logic [`BF16_W-1:0] scale_of(input logic [`BF16_W-1:0] v);
        int e;
        e = int'(v[14:7]) - `BF16_INT8_SHIFT;
        if (class_of(v) == bf16_pkg::BF16_INF) return 16'h7F80;
        if (class_of(v) == bf16_pkg::BF16_NAN) return 16'h7FC0;
        if (class_of(v) == bf16_pkg::BF16_ZERO || e < 1) return 16'h0000;
        return {1'b0, 8'(e), 7'h00};
    endfunction

    // ------------------------------
    // Beat folding
    // ------------------------------
    task automatic fold_beat();
        logic [`BF16_W-1:0] pair_lo;
        logic [`BF16_W-1:0] pair_hi;
        pair_lo = larger_mag(i_data[0*`BF16_W +: `BF16_W], i_data[1*`BF16_W +: `BF16_W]);
        pair_hi = larger_mag(i_data[2*`BF16_W +: `BF16_W], i_data[3*`BF16_W +: `BF16_W]);
        // Earlier beats sit on the a side
        run_max  = in_block ? larger_mag(run_max, larger_mag(pair_lo, pair_hi))
                            : larger_mag(pair_lo, pair_hi);
        in_block = 1'b1;
        if (i_last) begin
            max_q.push_back(run_max);
            due_q.push_back(cycle + 3);
            pending  = pending + 1;
            in_block = 1'b0;
        end
    endtask

    task automatic check_result();
        logic [`BF16_W-1:0]    want_max;
        longint                want_cycle;
        bf16_pkg::bf16_class_e want_class;
        logic [`BF16_W-1:0]    want_scale;
        if (max_q.size() == 0) begin
            other_errors = other_errors + 1;
            $display("Unexpected o_done at %0t ns with no block outstanding", $time);
        end else begin
            want_max    = max_q.pop_front();
            want_cycle  = due_q.pop_front();
            want_class  = class_of(want_max);
            want_scale  = scale_of(want_max);
            pending     = pending - 1;
            blocks_done = blocks_done + 1;
            if (cycle != want_cycle) begin
                other_errors = other_errors + 1;
                $display("Block %0d finished at cycle %0d instead of cycle %0d",
                         blocks_done, cycle, want_cycle);
            end
            if (i_block_max !== want_max || i_max_class !== want_class ||
                i_shared_exp !== want_max[14:7] || i_scale !== want_scale) begin
                value_errors = value_errors + 1;
                $display("ERROR %0t: block %0d got max %h class %0d exp %h scale %h, %s",
                         $time, blocks_done, i_block_max, i_max_class, i_shared_exp,
                         i_scale, $sformatf("expected max %h class %0d exp %h scale %h",
                         want_max, want_class, want_max[14:7], want_scale));
            end
        end
    endtask

    // Inputs settle on the falling edge, sampled here on the rising one
    always @(posedge i_clk) begin
        cycle = cycle + 1;
        if (i_rst) begin
            in_block = 1'b0;
        end else begin
            if (i_done) begin
                check_result();
            end
            if (i_valid) begin
                fold_beat();
            end
        end
    end

endmodule : bf16_absmax_checker

`default_nettype wire

//--- source/bf16_absmax_quant_top.sv
// Top level of the BF16 block abs-max unit
// Beat tree, block accumulator and scale generator in a chain
// Closing beat to o_done is three cycles

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module bf16_absmax_quant_top (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic                           i_last,
    input  logic [`BF16_LANES*`BF16_W-1:0] i_data,
    output logic                           o_done,
    output logic [`BF16_W-1:0]             o_block_max,
    output bf16_pkg::bf16_class_e          o_max_class,
    output logic [7:0]                     o_shared_exp,
    output logic [`BF16_W-1:0]             o_scale
);

    // ------------------------------
    // Stage links
    // ------------------------------
    // Tree to accumulator
    logic               beat_valid;
    logic               beat_last;
    logic [`BF16_W-1:0] beat_max;
    // Accumulator to scale generator
    logic               blk_done;
    logic [`BF16_W-1:0] blk_max;

    // Stage 1, one beat to its winner
    bf16_absmax_tree u_tree (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_last  (i_last),
        .i_data  (i_data),
        .o_valid (beat_valid),
        .o_last  (beat_last),
        .o_max   (beat_max)
    );

    // Stage 2, fold beats of a block
    bf16_block_absmax u_block (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (beat_valid),
        .i_last  (beat_last),
        .i_max   (beat_max),
        .o_done  (blk_done),
        .o_max   (blk_max)
    );

    // Stage 3, class and scale
    bf16_scale_gen u_scale (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_done       (blk_done),
        .i_max        (blk_max),
        .o_done       (o_done),
        .o_block_max  (o_block_max),
        .o_max_class  (o_max_class),
        .o_shared_exp (o_shared_exp),
        .o_scale      (o_scale)
    );

endmodule : bf16_absmax_quant_top

`default_nettype wire

//--- source/bf16_scale_gen.sv
// Block max classification and power-of-two scale
// Registers max, class, shared exponent and scale on done

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module bf16_scale_gen (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_done,
    input  logic [`BF16_W-1:0]     i_max,
    output logic                   o_done,
    output logic [`BF16_W-1:0]     o_block_max,
    output bf16_pkg::bf16_class_e  o_max_class,
    output logic [7:0]             o_shared_exp,
    output logic [`BF16_W-1:0]     o_scale
);

    // Fields of the block max
    logic [7:0]            max_exp;
    logic [6:0]            max_mant;
    bf16_pkg::bf16_class_e max_class;
    logic [`BF16_W-1:0]    scale;

    assign max_exp  = i_max[14:7];
    assign max_mant = i_max[6:0];

    // ------------------------------
    // Class and scale
    // ------------------------------
    always_comb begin
        max_class = bf16_pkg::BF16_NORMAL;
        scale     = '0;
        if (max_exp == 8'h00) begin
            // Zero and subnormal, scale stays 0
            max_class = bf16_pkg::BF16_ZERO;
        end else if (max_exp == 8'hFF) begin
            if (max_mant == 7'h00) begin
                max_class = bf16_pkg::BF16_INF;
                scale     = 16'h7F80;
            end else begin
                // Canonical quiet NaN
                max_class = bf16_pkg::BF16_NAN;
                scale     = 16'h7FC0;
            end
        end else if (max_exp > 8'(`BF16_INT8_SHIFT)) begin
            // Positive, mantissa 0, exponent minus headroom
            scale = {1'b0, max_exp - 8'(`BF16_INT8_SHIFT), 7'h00};
        end
        // Normal with exponent below 7 flushes to 0
    end

    // Output register, loads only when a block closes
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_done       <= 1'b0;
            o_block_max  <= '0;
            o_max_class  <= bf16_pkg::BF16_ZERO;
            o_shared_exp <= '0;
            o_scale      <= '0;
        end else begin
            o_done <= i_done;
            if (i_done) begin
                o_block_max  <= i_max;
                o_max_class  <= max_class;
                o_shared_exp <= max_exp;
                o_scale      <= scale;
            end
        end
    end

    // Scale sign bit always clear
    a_scale_positive : assert property (
        @(posedge i_clk) disable iff (i_rst) !o_scale[`BF16_W-1]
    );

endmodule : bf16_scale_gen

`default_nettype wire

//--- source/bf16_block_absmax.sv
// Running abs-max across the beats of one block
// Idle/run FSM, running maximum and block result register
// Closing beat gives a done pulse one cycle later

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module bf16_block_absmax (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_last,
    input  logic [`BF16_W-1:0] i_max,
    output logic               o_done,
    output logic [`BF16_W-1:0] o_max
);

    // ------------------------------
    // State and running maximum
    // ------------------------------
    bf16_pkg::accum_state_e state;
    logic [`BF16_W-1:0]     run_max;

    // Running max against the new beat winner
    logic [`BF16_W-1:0]     fold_max;
    // Value after this beat, fresh load or fold
    logic [`BF16_W-1:0]     next_max;

    // Running max is operand a so earlier beats win ties
    math_bf16_comparator u_cmp_run (
        .i_a         (run_max),
        .i_b         (i_max),
        .o_max       (fold_max),
        .o_a_greater (),
        .o_equal     ()
    );

    // First beat of a block loads straight in
    assign next_max = (state == bf16_pkg::ACC_IDLE) ? i_max : fold_max;

    // ------------------------------
    // Accumulator FSM
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= bf16_pkg::ACC_IDLE;
            run_max <= '0;
            o_max   <= '0;
            o_done  <= 1'b0;
        end else begin
            // Pulse by default
            o_done <= 1'b0;
            if (i_valid) begin
                if (i_last) begin
                    // Block closes, result out, ready for the next block
                    o_max  <= next_max;
                    o_done <= 1'b1;
                    state  <= bf16_pkg::ACC_IDLE;
                end else begin
                    run_max <= next_max;
                    state   <= bf16_pkg::ACC_RUN;
                end
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Single pulse unless another closing beat follows at once
    a_done_one_cycle : assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_done && !(i_valid && i_last)) |=> !o_done
    );

    // Every done traces back to a closing beat
    a_done_after_last : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_done |-> $past(i_valid && i_last)
    );

endmodule : bf16_block_absmax

`default_nettype wire

//--- source/bf16_absmax_tree.sv
// Four-lane BF16 abs-max tree, one register stage
// Pairs lane 0/1 and 2/3, then the two pair winners

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module bf16_absmax_tree (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic                           i_last,
    input  logic [`BF16_LANES*`BF16_W-1:0] i_data,
    output logic                           o_valid,
    output logic                           o_last,
    output logic [`BF16_W-1:0]             o_max
);

    // Pair winners and beat winner
    logic [`BF16_W-1:0] max_01;
    logic [`BF16_W-1:0] max_23;
    logic [`BF16_W-1:0] max_beat;

    // ------------------------------
    // Fixed pairing, earlier lane as a
    // ------------------------------
    math_bf16_comparator u_cmp_01 (
        .i_a         (i_data[0*`BF16_W +: `BF16_W]),
        .i_b         (i_data[1*`BF16_W +: `BF16_W]),
        .o_max       (max_01),
        .o_a_greater (),
        .o_equal     ()
    );

    math_bf16_comparator u_cmp_23 (
        .i_a         (i_data[2*`BF16_W +: `BF16_W]),
        .i_b         (i_data[3*`BF16_W +: `BF16_W]),
        .o_max       (max_23),
        .o_a_greater (),
        .o_equal     ()
    );

    // Lanes 0/1 winner stays first
    math_bf16_comparator u_cmp_fin (
        .i_a         (max_01),
        .i_b         (max_23),
        .o_max       (max_beat),
        .o_a_greater (),
        .o_equal     ()
    );

    // Beat register, winner only loads on a valid beat
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
            o_max   <= '0;
        end else begin
            o_valid <= i_valid;
            // Last is qualified here so it never stands alone
            o_last  <= i_valid && i_last;
            if (i_valid) begin
                o_max <= max_beat;
            end
        end
    end

    // Last strobe only rides on a valid beat
    a_last_needs_valid : assert property (
        @(posedge i_clk) disable iff (i_rst) o_last |-> o_valid
    );

endmodule : bf16_absmax_tree

`default_nettype wire

//--- source/math_bf16_comparator.sv
// BF16 magnitude comparator, purely combinational
// Returns the operand with the larger magnitude, sign kept
// NaN wins first, a wins a double NaN, ties go to a

`timescale 1ns/1ps
`default_nettype none

`include "bf16_quant_settings.svh"

module math_bf16_comparator (
    input  logic [`BF16_W-1:0] i_a,
    input  logic [`BF16_W-1:0] i_b,
    output logic [`BF16_W-1:0] o_max,
    output logic               o_a_greater,
    output logic               o_equal
);

    // ------------------------------
    // Field split
    // ------------------------------
    logic [7:0]  exp_a;
    logic [7:0]  exp_b;
    logic [6:0]  mant_a;
    logic [6:0]  mant_b;
    // Sign dropped, exponent on top so plain compare orders them
    logic [14:0] mag_a;
    logic [14:0] mag_b;

    // Special value flags
    logic a_nan;
    logic b_nan;
    logic a_inf;
    logic b_inf;

    assign exp_a  = i_a[14:7];
    assign exp_b  = i_b[14:7];
    assign mant_a = i_a[6:0];
    assign mant_b = i_b[6:0];
    assign mag_a  = i_a[14:0];
    assign mag_b  = i_b[14:0];

    // All-ones exponent, mantissa picks NaN vs infinity
    assign a_nan = (exp_a == 8'hFF) && (mant_a != 7'h00);
    assign b_nan = (exp_b == 8'hFF) && (mant_b != 7'h00);
    assign a_inf = (exp_a == 8'hFF) && (mant_a == 7'h00);
    assign b_inf = (exp_b == 8'hFF) && (mant_b == 7'h00);

    // ------------------------------
    // Winner select
    // ------------------------------
    always_comb begin
        o_max       = i_b;
        o_a_greater = 1'b0;
        o_equal     = 1'b0;
        if (a_nan) begin
            // First NaN holds, also on NaN vs NaN
            o_max       = i_a;
            o_a_greater = 1'b1;
        end else if (b_nan) begin
            o_max       = i_b;
        end else if (a_inf || b_inf) begin
            // Infinity over any finite value, two infinities tie
            o_max       = a_inf ? i_a : i_b;
            o_a_greater = a_inf && !b_inf;
            o_equal     = a_inf && b_inf;
        end else if (mag_a == mag_b) begin
            // Tie, earlier operand kept, +0 vs -0 included
            o_max       = i_a;
            o_equal     = 1'b1;
        end else if (mag_a > mag_b) begin
            o_max       = i_a;
            o_a_greater = 1'b1;
        end else begin
            o_max       = i_b;
        end
    end

endmodule : math_bf16_comparator

`default_nettype wire

//--- source/bf16_pkg.sv
// Types for the BF16 block abs-max unit
// Value class of the block maximum
// Block accumulator state

`default_nettype none

package bf16_pkg;

    // ------------------------------
    // Value class
    // ------------------------------
    // Subnormals fall into zero, exponent 0 only
    typedef enum logic [1:0] {
        BF16_ZERO   = 2'd0,
        BF16_NORMAL = 2'd1,
        BF16_INF    = 2'd2,
        BF16_NAN    = 2'd3
    } bf16_class_e;

    // ------------------------------
    // Accumulator state
    // ------------------------------
    // Idle waits for the first beat, run folds later beats
    typedef enum logic {
        ACC_IDLE = 1'b0,
        ACC_RUN  = 1'b1
    } accum_state_e;

endpackage : bf16_pkg

`default_nettype wire

//--- source/bf16_quant_settings.svh
// Shared sizing for the BF16 block abs-max unit
// Lane count per beat, BF16 word width and int8 exponent headroom

`ifndef BF16_QUANT_SETTINGS_SVH
`define BF16_QUANT_SETTINGS_SVH

// ------------------------------
// Beat geometry
// ------------------------------
// Values carried per beat, lane 0 in the low bits
`define BF16_LANES 4
// One BF16 word, sign + 8b exponent + 7b mantissa
`define BF16_W 16

// ------------------------------
// Scale derivation
// ------------------------------
// Exponent headroom so the scaled max lands in [64,128)
`define BF16_INT8_SHIFT 6

`endif
